//--- hdl/rv_pkg.sv
package rv_pkg;

    // **************************************************
    // Widths and fixed encodings
    // **************************************************
    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    localparam logic [xlen-1:0] nop_instr = 32'h0000_0013; // addi x0, x0, 0.

    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_branch = 7'b1100011;

    localparam logic [2:0] f3_add  = 3'b000; // Shared by add, sub and addi.
    localparam logic [2:0] f3_slt  = 3'b010;
    localparam logic [2:0] f3_sltu = 3'b011;
    localparam logic [2:0] f3_xor  = 3'b100;
    localparam logic [2:0] f3_or   = 3'b110;
    localparam logic [2:0] f3_and  = 3'b111;
    localparam logic [2:0] f3_lw   = 3'b010;
    localparam logic [2:0] f3_sw   = 3'b010;
    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;

    localparam logic [6:0] f7_sub = 7'b0100000;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_sltu
    } alu_op_e;

    typedef enum logic [1:0] {
        pipe_run,
        pipe_pause,
        pipe_flush
    } pipe_ctrl_e;

    typedef enum logic [1:0] {
        fwd_none,
        fwd_mem,
        fwd_wb
    } fwd_sel_e;

    // One instruction word, seen through each encoding format.
    typedef union packed {
        struct packed {
            logic [6:0]            funct7;
            logic [reg_addr_w-1:0] rs2;
            logic [reg_addr_w-1:0] rs1;
            logic [2:0]            funct3;
            logic [reg_addr_w-1:0] rd;
            logic [6:0]            opcode;
        } r;
        struct packed {
            logic [11:0]           imm;
            logic [reg_addr_w-1:0] rs1;
            logic [2:0]            funct3;
            logic [reg_addr_w-1:0] rd;
            logic [6:0]            opcode;
        } i;
        struct packed {
            logic [6:0]            imm_hi;
            logic [reg_addr_w-1:0] rs2;
            logic [reg_addr_w-1:0] rs1;
            logic [2:0]            funct3;
            logic [4:0]            imm_lo;
            logic [6:0]            opcode;
        } s;
        struct packed {
            logic                  imm_12;
            logic [5:0]            imm_10_5;
            logic [reg_addr_w-1:0] rs2;
            logic [reg_addr_w-1:0] rs1;
            logic [2:0]            funct3;
            logic [3:0]            imm_4_1;
            logic                  imm_11;
            logic [6:0]            opcode;
        } b;
    } instr_u;

endpackage

//--- hdl/hazard_if.sv
`timescale 1ns/1ns

interface hazard_if import rv_pkg::*; ();

    logic [reg_addr_w-1:0] id_rs1;
    logic [reg_addr_w-1:0] id_rs2;
    logic [reg_addr_w-1:0] ex_rs1;
    logic [reg_addr_w-1:0] ex_rs2;
    logic [reg_addr_w-1:0] ex_rd;
    logic                  ex_mem_read;
    logic [reg_addr_w-1:0] mem_rd;
    logic                  mem_reg_write;
    logic [reg_addr_w-1:0] wb_rd;
    logic                  wb_reg_write;
    logic                  branch_taken;

    fwd_sel_e   fwd_a;
    fwd_sel_e   fwd_b;
    pipe_ctrl_e pc_ctrl;
    pipe_ctrl_e if_id_ctrl;
    pipe_ctrl_e id_ex_ctrl;
    pipe_ctrl_e ex_mem_ctrl;
    pipe_ctrl_e mem_wb_ctrl;

    modport datapath (
        output id_rs1, id_rs2, ex_rs1, ex_rs2, ex_rd, ex_mem_read,
        output mem_rd, mem_reg_write, wb_rd, wb_reg_write, branch_taken,
        input  fwd_a, fwd_b, pc_ctrl, if_id_ctrl, id_ex_ctrl, ex_mem_ctrl, mem_wb_ctrl
    );

    modport hazard (
        input  id_rs1, id_rs2, ex_rs1, ex_rs2, ex_rd, ex_mem_read,
        input  mem_rd, mem_reg_write, wb_rd, wb_reg_write, branch_taken,
        output fwd_a, fwd_b, pc_ctrl, if_id_ctrl, id_ex_ctrl, ex_mem_ctrl, mem_wb_ctrl
    );

endinterface

//--- hdl/instr_decoder.sv
`timescale 1ns/1ns

module instr_decoder import rv_pkg::*; (
    input  instr_u                instr,
    output logic [reg_addr_w-1:0] rs1,
    output logic [reg_addr_w-1:0] rs2,
    output logic [reg_addr_w-1:0] rd,
    output logic [xlen-1:0]       imm,
    output alu_op_e               alu_op,
    output logic                  alu_b_imm,
    output logic                  reg_write,
    output logic                  mem_read,
    output logic                  mem_write,
    output logic                  branch,
    output logic                  branch_ne
);

    logic [xlen-1:0] imm_i;
    logic [xlen-1:0] imm_s;
    logic [xlen-1:0] imm_b;

    assign imm_i = {{(xlen-12){instr.i.imm[11]}}, instr.i.imm};
    assign imm_s = {{(xlen-12){instr.s.imm_hi[6]}}, instr.s.imm_hi, instr.s.imm_lo};
    assign imm_b = {{(xlen-12){instr.b.imm_12}}, instr.b.imm_11, instr.b.imm_10_5,
                    instr.b.imm_4_1, 1'b0};

    always_comb begin
        rs1       = '0;
        rs2       = '0;
        rd        = '0;
        imm       = '0;
        alu_op    = alu_add;
        alu_b_imm = 1'b0;
        reg_write = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        branch    = 1'b0;
        branch_ne = 1'b0;
        case (instr.r.opcode)
            op_reg: begin
                rs1       = instr.r.rs1;
                rs2       = instr.r.rs2;
                rd        = instr.r.rd;
                reg_write = 1'b1;
                case (instr.r.funct3)
                    f3_add:  alu_op = (instr.r.funct7 == f7_sub) ? alu_sub : alu_add;
                    f3_and:  alu_op = alu_and;
                    f3_or:   alu_op = alu_or;
                    f3_xor:  alu_op = alu_xor;
                    f3_slt:  alu_op = alu_slt;
                    f3_sltu: alu_op = alu_sltu;
                    default: reg_write = 1'b0; // Unsupported, behaves as a no-op.
                endcase
            end
            op_imm: begin
                rs1       = instr.i.rs1;
                rd        = instr.i.rd;
                imm       = imm_i;
                alu_b_imm = 1'b1;
                reg_write = 1'b1;
                case (instr.i.funct3)
                    f3_add:  alu_op = alu_add;
                    f3_and:  alu_op = alu_and;
                    f3_or:   alu_op = alu_or;
                    f3_xor:  alu_op = alu_xor;
                    f3_slt:  alu_op = alu_slt;
                    default: reg_write = 1'b0;
                endcase
            end
            op_load: begin
                if (instr.i.funct3 == f3_lw) begin
                    rs1       = instr.i.rs1;
                    rd        = instr.i.rd;
                    imm       = imm_i;
                    alu_b_imm = 1'b1;
                    reg_write = 1'b1;
                    mem_read  = 1'b1;
                end
            end
            op_store: begin
                if (instr.s.funct3 == f3_sw) begin
                    rs1       = instr.s.rs1;
                    rs2       = instr.s.rs2;
                    imm       = imm_s;
                    alu_b_imm = 1'b1;
                    mem_write = 1'b1;
                end
            end
            op_branch: begin
                rs1    = instr.b.rs1;
                rs2    = instr.b.rs2;
                imm    = imm_b;
                alu_op = alu_sub; // Compare through the zero flag.
                case (instr.b.funct3)
                    f3_beq:  branch = 1'b1;
                    f3_bne: begin
                        branch    = 1'b1;
                        branch_ne = 1'b1;
                    end
                    default: branch = 1'b0;
                endcase
            end
            default: ;
        endcase
    end

endmodule

//--- hdl/reg_file.sv
`timescale 1ns/1ns

module reg_file import rv_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [reg_addr_w-1:0] rs1,
    input  logic [reg_addr_w-1:0] rs2,
    input  logic [reg_addr_w-1:0] rd,
    input  logic [xlen-1:0]       wdata,
    input  logic                  we,
    output logic [xlen-1:0]       rdata1,
    output logic [xlen-1:0]       rdata2
);

    logic [xlen-1:0] regs [1:2**reg_addr_w-1]; // No storage for x0.

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 1; i < 2**reg_addr_w; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin
            regs[rd] <= wdata;
        end
    end

    // Same-cycle write is seen by the reader.
    assign rdata1 = (rs1 == '0) ? '0 : (we && rs1 == rd) ? wdata : regs[rs1];
    assign rdata2 = (rs2 == '0) ? '0 : (we && rs2 == rd) ? wdata : regs[rs2];

endmodule

//--- hdl/alu.sv
`timescale 1ns/1ns

module alu import rv_pkg::*; (
    input  logic [xlen-1:0] a,
    input  logic [xlen-1:0] b,
    input  alu_op_e         op,
    output logic [xlen-1:0] result,
    output logic            zero
);

    always_comb begin
        case (op)
            alu_add:  result = a + b;
            alu_sub:  result = a - b;
            alu_and:  result = a & b;
            alu_or:   result = a | b;
            alu_xor:  result = a ^ b;
            alu_slt:  result = xlen'($signed(a) < $signed(b));
            alu_sltu: result = xlen'(a < b);
            default:  result = '0;
        endcase
    end

    assign zero = (result == '0); // Equal operands under alu_sub.

endmodule

//--- hdl/hazard_unit.sv
`timescale 1ns/1ns

module hazard_unit import rv_pkg::*; (
    hazard_if.hazard hz
);

    logic stall;

    function automatic fwd_sel_e pick_fwd(
        input logic [reg_addr_w-1:0] rs,
        input logic [reg_addr_w-1:0] mem_rd,
        input logic                  mem_we,
        input logic [reg_addr_w-1:0] wb_rd,
        input logic                  wb_we
    );
        if (mem_we && mem_rd != '0 && mem_rd == rs) begin
            pick_fwd = fwd_mem; // Youngest result wins.
        end else if (wb_we && wb_rd != '0 && wb_rd == rs) begin
            pick_fwd = fwd_wb;
        end else begin
            pick_fwd = fwd_none;
        end
    endfunction

    assign hz.fwd_a = pick_fwd(hz.ex_rs1, hz.mem_rd, hz.mem_reg_write, hz.wb_rd, hz.wb_reg_write);
    assign hz.fwd_b = pick_fwd(hz.ex_rs2, hz.mem_rd, hz.mem_reg_write, hz.wb_rd, hz.wb_reg_write);

    // Load in execute feeds the instruction in decode.
    assign stall = hz.ex_mem_read && (hz.ex_rd != '0)
                   && (hz.ex_rd == hz.id_rs1 || hz.ex_rd == hz.id_rs2);

    always_comb begin
        hz.pc_ctrl     = pipe_run;
        hz.if_id_ctrl  = pipe_run;
        hz.id_ex_ctrl  = pipe_run;
        hz.ex_mem_ctrl = pipe_run;
        hz.mem_wb_ctrl = pipe_run;
        if (hz.branch_taken) begin
            hz.pc_ctrl     = pipe_flush; // PC loads the branch target.
            hz.if_id_ctrl  = pipe_flush;
            hz.id_ex_ctrl  = pipe_flush;
            hz.ex_mem_ctrl = pipe_flush;
        end else if (stall) begin
            hz.pc_ctrl    = pipe_pause;
            hz.if_id_ctrl = pipe_pause;
            hz.id_ex_ctrl = pipe_flush; // Bubble into execute.
        end
    end

endmodule

//--- hdl/rv_pipeline.sv
`timescale 1ns/1ns

module rv_pipeline import rv_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    output logic [xlen-1:0] imem_addr,
    input  logic [xlen-1:0] imem_data,
    output logic [xlen-1:0] dmem_addr,
    output logic [xlen-1:0] dmem_wdata,
    output logic            dmem_we,
    input  logic [xlen-1:0] dmem_rdata
);

    hazard_if hz ();

    logic [xlen-1:0] pc;

    logic [xlen-1:0]       id_pc;
    instr_u                id_instr;
    logic [reg_addr_w-1:0] id_rs1, id_rs2, id_rd;
    logic [xlen-1:0]       id_imm, id_rs1_data, id_rs2_data;
    alu_op_e               id_alu_op;
    logic                  id_alu_b_imm, id_reg_write, id_mem_read, id_mem_write;
    logic                  id_branch, id_branch_ne;

    logic [xlen-1:0]       ex_pc, ex_imm, ex_rs1_data, ex_rs2_data;
    logic [reg_addr_w-1:0] ex_rs1, ex_rs2, ex_rd;
    alu_op_e               ex_alu_op;
    logic                  ex_alu_b_imm, ex_reg_write, ex_mem_read, ex_mem_write;
    logic                  ex_branch, ex_branch_ne;
    logic [xlen-1:0]       ex_op_a, ex_op_b, ex_alu_b, ex_alu_result, ex_br_target;
    logic                  ex_zero;

    logic [xlen-1:0]       mem_alu_result, mem_store_data, mem_br_target;
    logic [reg_addr_w-1:0] mem_rd;
    logic                  mem_zero, mem_reg_write, mem_load, mem_store;
    logic                  mem_branch, mem_branch_ne;

    logic [xlen-1:0]       wb_alu_result, wb_load_data, wb_data;
    logic [reg_addr_w-1:0] wb_rd;
    logic                  wb_reg_write, wb_load;

    function automatic logic [xlen-1:0] fwd_mux(
        input fwd_sel_e        sel,
        input logic [xlen-1:0] reg_val,
        input logic [xlen-1:0] mem_val,
        input logic [xlen-1:0] wb_val
    );
        case (sel)
            fwd_mem: fwd_mux = mem_val;
            fwd_wb:  fwd_mux = wb_val;
            default: fwd_mux = reg_val;
        endcase
    endfunction

    assign hz.id_rs1        = id_rs1;
    assign hz.id_rs2        = id_rs2;
    assign hz.ex_rs1        = ex_rs1;
    assign hz.ex_rs2        = ex_rs2;
    assign hz.ex_rd         = ex_rd;
    assign hz.ex_mem_read   = ex_mem_read;
    assign hz.mem_rd        = mem_rd;
    assign hz.mem_reg_write = mem_reg_write;
    assign hz.wb_rd         = wb_rd;
    assign hz.wb_reg_write  = wb_reg_write;

    hazard_unit u_hazard (
        .hz (hz)
    );

    // **************************************************
    // Fetch
    // **************************************************
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= '0;
        end else begin
            case (hz.pc_ctrl)
                pipe_run:   pc <= pc + xlen'(4);
                pipe_flush: pc <= mem_br_target; // Redirect on taken branch.
                default:    pc <= pc;
            endcase
        end
    end

    assign imem_addr = pc;

    always_ff @(posedge clk) begin
        if (!rst_n || hz.if_id_ctrl == pipe_flush) begin
            id_instr <= nop_instr;
        end else if (hz.if_id_ctrl == pipe_run) begin
            id_instr <= imem_data;
            id_pc    <= pc;
        end
    end

    // **************************************************
    // Decode
    // **************************************************
    instr_decoder u_decoder (
        .instr     (id_instr),
        .rs1       (id_rs1),
        .rs2       (id_rs2),
        .rd        (id_rd),
        .imm       (id_imm),
        .alu_op    (id_alu_op),
        .alu_b_imm (id_alu_b_imm),
        .reg_write (id_reg_write),
        .mem_read  (id_mem_read),
        .mem_write (id_mem_write),
        .branch    (id_branch),
        .branch_ne (id_branch_ne)
    );

    reg_file u_regs (
        .clk    (clk),
        .rst_n  (rst_n),
        .rs1    (id_rs1),
        .rs2    (id_rs2),
        .rd     (wb_rd),
        .wdata  (wb_data),
        .we     (wb_reg_write),
        .rdata1 (id_rs1_data),
        .rdata2 (id_rs2_data)
    );

    always_ff @(posedge clk) begin
        if (!rst_n || hz.id_ex_ctrl == pipe_flush) begin
            ex_reg_write <= 1'b0;
            ex_mem_read  <= 1'b0;
            ex_mem_write <= 1'b0;
            ex_branch    <= 1'b0;
        end else if (hz.id_ex_ctrl == pipe_run) begin
            ex_reg_write <= id_reg_write;
            ex_mem_read  <= id_mem_read;
            ex_mem_write <= id_mem_write;
            ex_branch    <= id_branch;
            ex_branch_ne <= id_branch_ne;
            ex_alu_op    <= id_alu_op;
            ex_alu_b_imm <= id_alu_b_imm;
            ex_pc        <= id_pc;
            ex_imm       <= id_imm;
            ex_rs1_data  <= id_rs1_data;
            ex_rs2_data  <= id_rs2_data;
            ex_rs1       <= id_rs1;
            ex_rs2       <= id_rs2;
            ex_rd        <= id_rd;
        end
    end

    // **************************************************
    // Execute
    // **************************************************
    assign ex_op_a      = fwd_mux(hz.fwd_a, ex_rs1_data, mem_alu_result, wb_data);
    assign ex_op_b      = fwd_mux(hz.fwd_b, ex_rs2_data, mem_alu_result, wb_data);
    assign ex_alu_b     = ex_alu_b_imm ? ex_imm : ex_op_b;
    assign ex_br_target = ex_pc + ex_imm;

    alu u_alu (
        .a      (ex_op_a),
        .b      (ex_alu_b),
        .op     (ex_alu_op),
        .result (ex_alu_result),
        .zero   (ex_zero)
    );

    always_ff @(posedge clk) begin
        if (!rst_n || hz.ex_mem_ctrl == pipe_flush) begin
            mem_reg_write <= 1'b0;
            mem_load      <= 1'b0;
            mem_store     <= 1'b0;
            mem_branch    <= 1'b0;
        end else if (hz.ex_mem_ctrl == pipe_run) begin
            mem_reg_write  <= ex_reg_write;
            mem_load       <= ex_mem_read;
            mem_store      <= ex_mem_write;
            mem_branch     <= ex_branch;
            mem_branch_ne  <= ex_branch_ne;
            mem_alu_result <= ex_alu_result;
            mem_store_data <= ex_op_b; // Forwarded rs2.
            mem_br_target  <= ex_br_target;
            mem_zero       <= ex_zero;
            mem_rd         <= ex_rd;
        end
    end

    // **************************************************
    // Memory
    // **************************************************
    assign hz.branch_taken = mem_branch && (mem_zero ^ mem_branch_ne);

    assign dmem_addr  = mem_alu_result;
    assign dmem_wdata = mem_store_data;
    assign dmem_we    = mem_store;

    always_ff @(posedge clk) begin
        if (!rst_n || hz.mem_wb_ctrl == pipe_flush) begin
            wb_reg_write <= 1'b0;
            wb_load      <= 1'b0;
        end else if (hz.mem_wb_ctrl == pipe_run) begin
            wb_reg_write  <= mem_reg_write;
            wb_load       <= mem_load;
            wb_rd         <= mem_rd;
            wb_alu_result <= mem_alu_result;
            wb_load_data  <= dmem_rdata;
        end
    end

    // Writeback.
    assign wb_data = wb_load ? wb_load_data : wb_alu_result;

endmodule

//--- sim/rv_pipeline_props.sv
`timescale 1ns/1ns

module rv_pipeline_props import rv_pkg::*; (
    input logic                  clk,
    input logic                  rst_n,
    input pipe_ctrl_e            pc_ctrl,
    input fwd_sel_e              fwd_a,
    input fwd_sel_e              fwd_b,
    input logic [reg_addr_w-1:0] mem_rd,
    input logic                  dmem_we
);

    // A load-use stall shows as a paused PC.
    assert property (@(posedge clk) disable iff (!rst_n)
        (pc_ctrl == pipe_pause) |=> (pc_ctrl != pipe_pause))
        else $error("Load-use stall lasted two cycles in a row");

    assert property (@(posedge clk) disable iff (!rst_n)
        (mem_rd == '0) |-> (fwd_a != fwd_mem && fwd_b != fwd_mem))
        else $error("Forwarding from memory stage selected with mem_rd of zero");

    assert property (@(posedge clk) !rst_n |=> !dmem_we)
        else $error("Data memory write enable high during reset");

endmodule

bind rv_pipeline rv_pipeline_props u_props (
    .clk     (clk),
    .rst_n   (rst_n),
    .pc_ctrl (hz.pc_ctrl),
    .fwd_a   (hz.fwd_a),
    .fwd_b   (hz.fwd_b),
    .mem_rd  (hz.mem_rd),
    .dmem_we (dmem_we)
);

//--- sim/rv_pipeline_tb.sv
`timescale 1ns/1ns

module rv_pipeline_tb import rv_pkg::*; ();

    localparam int imem_words = 256;
    localparam int body_len   = 56;
    localparam int body_end   = 31 + body_len; // First of the two padding no-ops.

    logic            clk;
    logic            rst_n;
    logic [xlen-1:0] imem_addr;
    logic [xlen-1:0] imem_data;
    logic [xlen-1:0] dmem_addr;
    logic [xlen-1:0] dmem_wdata;
    logic            dmem_we;
    logic [xlen-1:0] dmem_rdata;

    instr_u          prog [imem_words];
    logic [xlen-1:0] dmem [64] = '{default: '0};
    logic [xlen-1:0] exp_addr [$];
    logic [xlen-1:0] exp_data [$];
    int              prog_len = 0;
    int              seen = 0;

    rv_pipeline dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .imem_addr  (imem_addr),
        .imem_data  (imem_data),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_we    (dmem_we),
        .dmem_rdata (dmem_rdata)
    );

    always #10 clk = ~clk;

    assign imem_data  = (imem_addr < 32'(imem_words * 4)) ? prog[imem_addr[9:2]] : nop_instr;
    assign dmem_rdata = dmem[dmem_addr[7:2]];

    always @(posedge clk) begin
        if (dmem_we) begin
            dmem[dmem_addr[7:2]] <= dmem_wdata;
        end
    end

    // **************************************************
    // Reporting
    // **************************************************
    task automatic end_with_failure();
        $display("Testbench failed");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
        if (got !== exp) begin
            $display("Error %s: expected %h got %h", name, exp, got);
            end_with_failure();
        end
    endtask

    // **************************************************
    // Program generator
    // **************************************************
    function automatic instr_u r_word(input logic [6:0] f7, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3,
                                      input logic [4:0] rd);
        instr_u w;
        w.r = '{f7, rs2, rs1, f3, rd, op_reg};
        return w;
    endfunction

    function automatic instr_u i_word(input logic [11:0] imm, input logic [4:0] rs1,
                                      input logic [2:0] f3, input logic [4:0] rd,
                                      input logic [6:0] opcode);
        instr_u w;
        w.i = '{imm, rs1, f3, rd, opcode};
        return w;
    endfunction

    function automatic instr_u s_word(input logic [11:0] imm, input logic [4:0] rs2,
                                      input logic [4:0] rs1);
        instr_u w;
        w.s = '{imm[11:5], rs2, rs1, f3_sw, imm[4:0], op_store};
        return w;
    endfunction

    function automatic instr_u b_word(input logic [2:0] f3, input logic [4:0] rs1,
                                      input logic [4:0] rs2, input logic [12:0] off);
        instr_u w;
        w.b = '{off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], op_branch};
        return w;
    endfunction

    function automatic logic [2:0] funct3_for(input int sel);
        case (sel)
            0, 1:    return f3_add;
            2:       return f3_and;
            3:       return f3_or;
            4:       return f3_xor;
            5:       return f3_slt;
            default: return f3_sltu;
        endcase
    endfunction

    task automatic gen_program();
        int         k;
        int         kind;
        int         sel;
        int         span;
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        for (int i = 0; i < imem_words; i++) begin
            prog[i] = nop_instr;
        end
        for (int i = 1; i < 32; i++) begin
            prog[i - 1] = i_word(12'($urandom), 5'd0, f3_add, 5'(i), op_imm);
        end
        k = 31;
        while (k < body_end) begin
            rd    = 5'($urandom_range(31, 1));
            rs1   = 5'($urandom_range(31, 0));
            rs2   = 5'($urandom_range(31, 0));
            kind  = $urandom_range(9, 0);
            span  = $urandom_range(6, 2);
            if (k + span > body_end) begin
                span = body_end - k;
            end
            if (kind >= 8 && span < 2) begin
                kind = 3; // No room left for a branch.
            end
            if (kind == 7 && k + 1 >= body_end) begin
                kind = 5;
            end
            case (kind)
                0, 1, 2: begin
                    sel     = $urandom_range(6, 0);
                    prog[k] = r_word((sel == 1) ? f7_sub : 7'd0, rs2, rs1, funct3_for(sel), rd);
                end
                3, 4: begin
                    sel = $urandom_range(4, 0);
                    if (sel > 0) begin
                        sel = sel + 1;
                    end
                    prog[k] = i_word(12'($urandom), rs1, funct3_for(sel), rd, op_imm);
                end
                5: prog[k] = i_word(12'($urandom_range(63, 0) * 4), 5'd0, f3_lw, rd, op_load);
                6: prog[k] = s_word(12'($urandom_range(63, 0) * 4), rs2, 5'd0);
                7: begin
                    prog[k]     = i_word(12'($urandom_range(63, 0) * 4), 5'd0, f3_lw, rd,
                                         op_load);
                    prog[k + 1] = s_word(12'($urandom_range(63, 0) * 4), rd, 5'd0);
                    k = k + 1; // Store right behind its load.
                end
                default: begin
                    if ($urandom_range(1, 0) == 1) begin
                        rs2 = rs1;
                    end
                    prog[k] = b_word(($urandom_range(1, 0) == 1) ? f3_bne : f3_beq,
                                     rs1, rs2, 13'(span * 4));
                end
            endcase
            k = k + 1;
        end
        for (int i = 1; i < 32; i++) begin
            prog[body_end + 1 + i] = s_word(12'(128 + 4 * i), 5'(i), 5'd0);
        end
        prog_len = body_end + 33;
    endtask

    // **************************************************
    // Instruction-set model
    // **************************************************
    task automatic run_model();
        logic [31:0] regs [32];
        logic [31:0] mem [64];
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic [31:0] res;
        instr_u      w;
        int          pc;
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        for (int i = 0; i < 64; i++) begin
            mem[i] = '0;
        end
        pc = 0;
        while (pc < prog_len) begin
            w   = prog[pc];
            a   = regs[w.r.rs1];
            b   = regs[w.r.rs2];
            imm = {{20{w.i.imm[11]}}, w.i.imm};
            res = '0;
            pc  = pc + 1;
            case (w.r.opcode)
                op_reg, op_imm: begin
                    if (w.r.opcode == op_imm) begin
                        b = imm;
                    end
                    case (w.r.funct3)
                        f3_add: begin
                            res = (w.r.opcode == op_reg && w.r.funct7 == f7_sub) ? a - b
                                                                                 : a + b;
                        end
                        f3_and:  res = a & b;
                        f3_or:   res = a | b;
                        f3_xor:  res = a ^ b;
                        f3_slt:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default: res = (a < b) ? 32'd1 : 32'd0;
                    endcase
                end
                op_load: begin
                    res = a + imm;
                    res = mem[res[7:2]];
                end
                op_store: begin
                    res = a + {{20{w.s.imm_hi[6]}}, w.s.imm_hi, w.s.imm_lo};
                    mem[res[7:2]] = b;
                    exp_addr.push_back(res);
                    exp_data.push_back(b);
                end
                op_branch: begin
                    imm = {{19{w.b.imm_12}}, w.b.imm_12, w.b.imm_11, w.b.imm_10_5,
                           w.b.imm_4_1, 1'b0};
                    if ((a == b) != (w.b.funct3 == f3_bne)) begin
                        pc = pc - 1 + int'($signed(imm) >>> 2);
                    end
                end
                default: ;
            endcase
            if ((w.r.opcode == op_reg || w.r.opcode == op_imm || w.r.opcode == op_load)
                && w.r.rd != 5'd0) begin
                regs[w.r.rd] = res;
            end
        end
    endtask

    // **************************************************
    // Checker, watchdog and main sequence
    // **************************************************
    always @(negedge clk) begin
        if (rst_n) begin
            check_value("imem_addr[1:0]", 32'h0, 32'(imem_addr[1:0]));
            if (dmem_we && seen >= exp_addr.size()) begin
                $display("A store appeared that the program does not make, at address %h",
                         dmem_addr);
                end_with_failure();
            end else if (dmem_we) begin
                check_value("dmem_addr[1:0]", 32'h0, 32'(dmem_addr[1:0]));
                check_value("dmem_addr[31:8]", 32'h0, 32'(dmem_addr[31:8]));
                check_value("dmem_addr", exp_addr[seen], dmem_addr);
                check_value("dmem_wdata", exp_data[seen], dmem_wdata);
                seen = seen + 1;
            end
        end
    end

    initial begin
        wait (prog_len > 0);
        repeat ((prog_len + 50) * 4) @(posedge clk);
        $display("Timeout: the expected stores did not all appear, %0d of %0d seen",
                 seen, exp_addr.size());
        end_with_failure();
    end

    initial begin
        clk   = 1'b0;
        rst_n = 1'b0;
        void'($urandom(69));
        gen_program();
        run_model();
        for (int i = 0; i < 3; i++) begin
            @(posedge clk);
            if (i == 2) begin
                rst_n <= 1'b1;
            end
            @(negedge clk);
            check_value("dmem_we", 32'h0, 32'(dmem_we));
            check_value("imem_addr", 32'h0, imem_addr);
        end
        while (seen < exp_addr.size()) begin
            @(posedge clk);
        end
        repeat (20) @(negedge clk); // Extra stores would show up here.
        @(posedge clk);
        $display("Testbench passed");
        $finish;
    end

endmodule

//--- rv_pipeline.f
hdl/rv_pkg.sv
hdl/hazard_if.sv
hdl/instr_decoder.sv
hdl/reg_file.sv
hdl/alu.sv
hdl/hazard_unit.sv
hdl/rv_pipeline.sv
sim/rv_pipeline_props.sv
sim/rv_pipeline_tb.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := rv_pipeline_tb
FILELIST  := rv_pipeline.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the simulation with Verilator"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "Testbench passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
